// File: compile.f
+incdir+include
verilog/lsu_pkg.sv
verilog/lsu_if.sv
verilog/lsu_buffer_ram.sv
verilog/lsu_buffer_bank.sv
verilog/lsu_mxu_store.sv
verilog/lsu_dram_store.sv
verilog/lsu_instr_ctrl.sv
verilog/lsu_top.sv
verif/tb_lsu.sv

// File: include/lsu_config.svh
`ifndef LSU_CONFIG_SVH
`define LSU_CONFIG_SVH

// buffer and mxu row geometry
`define LSU_ROW_W      128
`define LSU_ROW_BYTES  16
`define LSU_MXU_ROWS   16

// axi write data width, one row is two beats
`define LSU_BEAT_W     64

// 256 rows per buffer
`define LSU_BUF_AW     8

// row count and dram address widths
`define LSU_NUM_W      8
`define LSU_DRAM_AW    31

// buffer select codes
`define LSU_BUF_IRAM   2'd0
`define LSU_BUF_WRAM   2'd1
`define LSU_BUF_ORAM   2'd2

// store opcodes
`define LSU_OP_ST_BUF  2'd0
`define LSU_OP_ST_DRAM 2'd1

`endif

// File: verif/tb_lsu.sv
`timescale 1ns/100ps
`include "lsu_config.svh"

module tb_lsu;
    // all tests together take a few hundred cycles
    localparam int TIMEOUT_CYCLES = 4000;

    logic          clk = 1'b0;
    logic          arst_n;
    logic          idu_vld;
    logic [1:0]    idu_op;
    logic [1:0]    idu_buf_sel;
    logic [7:0]    idu_buf_addr;
    logic [7:0]    idu_num;
    logic [3:0]    idu_start_x;
    logic [3:0]    idu_start_y;
    logic [4:0]    idu_len;
    logic [30:0]   idu_dram_addr;
    logic          idu_rdy;
    logic [2047:0] mxu_rows;
    logic          mxu_data_rdy;
    logic          axi_awrdy;
    logic          axi_wrdy;
    logic          axi_bvld;
    logic          axi_awvld;
    logic [30:0]   axi_awaddr;
    logic [7:0]    axi_awlen;
    logic          axi_wvld;
    logic [63:0]   axi_wdata;
    logic          axi_wlast;
    logic          axi_brdy;

    int           err_cnt = 0;
    int           cycle_cnt;
    int           seed;
    logic         stall_en;
    logic [127:0] mxu_img [16];
    logic [127:0] exp_mem [3][256];
    logic [30:0]  aw_addr_q [$];
    logic [7:0]   aw_len_q [$];
    logic [63:0]  w_data_q [$];
    logic         w_last_q [$];

    // axi slave response state
    bit b_req = 1'b0;
    bit b_ack = 1'b0;
    int b_delay = 0;

    // expected idu_rdy tracking
    bit       busy_exp = 1'b0;
    bit       first_exp;
    bit       resp_exp;
    bit [1:0] op_exp;
    int       num_exp;
    int       rows_seen;
    int       beats_seen;

    lsu_top DUT (.*);

    initial forever #2 clk = ~clk;

    task automatic check(input string name, input logic [127:0] got, input logic [127:0] exp);
        if (got !== exp) begin
            $display("ERR %s got %h exp %h", name, got, exp);
            err_cnt++;
        end
    endtask

    // ready and valid inputs change on the rising edge only
    always @(posedge clk) begin
        if (!arst_n) begin
            mxu_data_rdy <= 1'b0;
            axi_awrdy    <= 1'b0;
            axi_wrdy     <= 1'b0;
            axi_bvld     <= 1'b0;
        end else begin
            if (stall_en) begin
                mxu_data_rdy <= ($urandom % 2) == 0;
                axi_awrdy    <= ($urandom % 3) == 0;
                axi_wrdy     <= ($urandom % 2) == 0;
            end else begin
                mxu_data_rdy <= 1'b1;
                axi_awrdy    <= 1'b1;
                axi_wrdy     <= 1'b1;
            end
            if (b_ack) begin
                axi_bvld <= 1'b0;
                b_ack = 1'b0;
            end else if (b_req) begin
                if (b_delay == 0) begin
                    axi_bvld <= 1'b1;
                    b_req = 1'b0;
                end else begin
                    b_delay--;
                end
            end
        end
    end

    // handshakes are sampled mid-cycle where every signal is settled
    always @(negedge clk) begin
        if (arst_n) begin
            if (axi_awvld && axi_awrdy) begin
                aw_addr_q.push_back(axi_awaddr);
                aw_len_q.push_back(axi_awlen);
            end
            if (axi_wvld && axi_wrdy) begin
                w_data_q.push_back(axi_wdata);
                w_last_q.push_back(axi_wlast);
                if (axi_wlast) begin
                    b_req = 1'b1;
                    b_delay = $urandom % (stall_en ? 8 : 3);
                end
            end
            if (axi_bvld && axi_brdy) begin
                b_ack = 1'b1;
            end
            if (!busy_exp) begin
                check("idu_rdy", idu_rdy, 1'b1);
            end else if (first_exp) begin
                // start cycle, engine not yet running
                check("idu_rdy", idu_rdy, 1'b0);
                first_exp = 1'b0;
            end else if (op_exp == `LSU_OP_ST_BUF) begin
                if (mxu_data_rdy) begin
                    rows_seen++;
                end
                check("idu_rdy", idu_rdy, rows_seen == num_exp);
                if (rows_seen == num_exp) begin
                    busy_exp = 1'b0;
                end
            end else if (resp_exp) begin
                check("axi_brdy", axi_brdy, 1'b1);
                check("idu_rdy", idu_rdy, axi_bvld);
                if (axi_bvld) begin
                    busy_exp = 1'b0;
                end
            end else begin
                check("idu_rdy", idu_rdy, 1'b0);
                if (axi_wvld && axi_wrdy) begin
                    beats_seen++;
                end
                if (beats_seen == 2 * num_exp) begin
                    resp_exp = 1'b1;
                end
            end
            if (idu_vld && idu_rdy) begin
                busy_exp   = 1'b1;
                first_exp  = 1'b1;
                resp_exp   = 1'b0;
                op_exp     = idu_op;
                num_exp    = idu_num;
                rows_seen  = 0;
                beats_seen = 0;
            end
        end
    end

    task automatic load_mxu();
        logic [2047:0] img;
        for (int r = 0; r < 16; r++) begin
            mxu_img[r] = {$urandom, $urandom, $urandom, $urandom};
            img[r*128 +: 128] = mxu_img[r];
        end
        @(posedge clk);
        mxu_rows <= img;
    endtask

    // reference buffer contents after a buffer store
    function automatic void model_store(input logic [1:0] sel, input logic [7:0] addr,
                                        input logic [7:0] num, input logic [3:0] sx,
                                        input logic [3:0] sy, input logic [4:0] len);
        logic [127:0] src;
        for (int i = 0; i < num; i++) begin
            src = mxu_img[sy + i];
            for (int b = 0; b < 16; b++) begin
                if (b >= sx && b < sx + len) begin
                    exp_mem[sel][8'(addr + i)][b*8 +: 8] = src[b*8 +: 8];
                end
            end
        end
    endfunction

    // holds idu_vld until the DUT takes the instruction
    task automatic issue_instr(input logic [1:0] op, input logic [1:0] sel,
                               input logic [7:0] addr, input logic [7:0] num,
                               input logic [3:0] sx, input logic [3:0] sy,
                               input logic [4:0] len, input logic [30:0] dram);
        @(posedge clk);
        idu_vld       <= 1'b1;
        idu_op        <= op;
        idu_buf_sel   <= sel;
        idu_buf_addr  <= addr;
        idu_num       <= num;
        idu_start_x   <= sx;
        idu_start_y   <= sy;
        idu_len       <= len;
        idu_dram_addr <= dram;
        if (op == `LSU_OP_ST_BUF) begin
            model_store(sel, addr, num, sx, sy, len);
        end
        @(negedge clk);
        while (!idu_rdy) @(negedge clk);
        @(posedge clk);
        idu_vld <= 1'b0;
    endtask

    task automatic wait_idle();
        while (busy_exp) @(posedge clk);
    endtask

    task automatic clear_capture();
        aw_addr_q.delete();
        aw_len_q.delete();
        w_data_q.delete();
        w_last_q.delete();
    endtask

    task automatic check_drain(input logic [1:0] sel, input logic [7:0] addr,
                               input logic [7:0] num, input logic [30:0] dram);
        int           nb;
        logic [127:0] row;
        nb = 2 * num;
        check("aw_count", aw_addr_q.size(), 1);
        if (aw_addr_q.size() > 0) begin
            check("axi_awaddr", aw_addr_q[0], dram);
            check("axi_awlen", aw_len_q[0], nb - 1);
        end
        check("beat_count", w_data_q.size(), nb);
        for (int i = 0; i < nb && i < w_data_q.size(); i++) begin
            row = exp_mem[sel][8'(addr + i / 2)];
            check("axi_wdata", w_data_q[i], (i % 2) ? row[127:64] : row[63:0]);
            check("axi_wlast", w_last_q[i], i == nb - 1);
        end
    endtask

    task automatic store_rows(input logic [1:0] sel, input logic [7:0] addr,
                              input logic [7:0] num, input logic [3:0] sx,
                              input logic [3:0] sy, input logic [4:0] len);
        issue_instr(`LSU_OP_ST_BUF, sel, addr, num, sx, sy, len, 31'h0);
        wait_idle();
    endtask

    task automatic drain_rows(input logic [1:0] sel, input logic [7:0] addr,
                              input logic [7:0] num, input logic [30:0] dram);
        clear_capture();
        issue_instr(`LSU_OP_ST_DRAM, sel, addr, num, 4'd0, 4'd0, 5'd0, dram);
        wait_idle();
        check_drain(sel, addr, num, dram);
    endtask

    task automatic check_reset_values();
        @(negedge clk);
        check("idu_rdy", idu_rdy, 1'b1);
        check("axi_awvld", axi_awvld, 1'b0);
        check("axi_wvld", axi_wvld, 1'b0);
        check("axi_wlast", axi_wlast, 1'b0);
        check("axi_brdy", axi_brdy, 1'b0);
    endtask

    task automatic full_row_store();
        load_mxu();
        store_rows(`LSU_BUF_ORAM, 8'd10, 8'd4, 4'd0, 4'd3, 5'd16);
        drain_rows(`LSU_BUF_ORAM, 8'd10, 8'd4, 31'h1000_0040);
    endtask

    task automatic column_mask();
        load_mxu();
        store_rows(`LSU_BUF_WRAM, 8'd40, 8'd1, 4'd0, 4'd0, 5'd16);
        // second pattern only over bytes 5 to 10
        load_mxu();
        store_rows(`LSU_BUF_WRAM, 8'd40, 8'd1, 4'd5, 4'd7, 5'd6);
        drain_rows(`LSU_BUF_WRAM, 8'd40, 8'd1, 31'h0000_2000);
    endtask

    task automatic buffer_independence();
        for (int s = 0; s < 3; s++) begin
            load_mxu();
            store_rows(s[1:0], 8'd100, 8'd2, 4'd0, 4'(s * 4), 5'd16);
        end
        for (int s = 0; s < 3; s++) begin
            drain_rows(s[1:0], 8'd100, 8'd2, 31'h0000_2100 + 31'(s * 'h100));
        end
    endtask

    task automatic back_pressure();
        stall_en <= 1'b1;
        load_mxu();
        store_rows(`LSU_BUF_IRAM, 8'd200, 8'd8, 4'd2, 4'd8, 5'd12);
        drain_rows(`LSU_BUF_IRAM, 8'd200, 8'd8, 31'h0000_3000);
        // rows written without stalls earlier
        drain_rows(`LSU_BUF_ORAM, 8'd10, 8'd4, 31'h0000_3400);
        @(posedge clk);
        stall_en <= 1'b0;
    endtask

    task automatic instr_holdoff();
        load_mxu();
        clear_capture();
        issue_instr(`LSU_OP_ST_BUF, `LSU_BUF_ORAM, 8'd60, 8'd5, 4'd1, 4'd11, 5'd14, 31'h0);
        // drain waits on idu_vld while the store runs
        issue_instr(`LSU_OP_ST_DRAM, `LSU_BUF_ORAM, 8'd60, 8'd5, 4'd0, 4'd0, 5'd0,
                    31'h0000_4000);
        wait_idle();
        check_drain(`LSU_BUF_ORAM, 8'd60, 8'd5, 31'h0000_4000);
    endtask

    initial begin
        cycle_cnt = 0;
        while (cycle_cnt < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("timeout after %0d cycles, the DUT did not finish the tests", cycle_cnt);
        err_cnt++;
        $display("errors: %0d", err_cnt);
        $display("FAIL: see errors above");
        $finish;
    end

    initial begin
        seed          = $urandom(32296);
        arst_n        = 1'b0;
        idu_vld       = 1'b0;
        idu_op        = 2'd0;
        idu_buf_sel   = 2'd0;
        idu_buf_addr  = 8'd0;
        idu_num       = 8'd0;
        idu_start_x   = 4'd0;
        idu_start_y   = 4'd0;
        idu_len       = 5'd0;
        idu_dram_addr = 31'd0;
        mxu_rows      = '0;
        mxu_data_rdy  = 1'b0;
        axi_awrdy     = 1'b0;
        axi_wrdy      = 1'b0;
        axi_bvld      = 1'b0;
        stall_en      = 1'b0;
        repeat (8) @(posedge clk);
        arst_n <= 1'b1;
        check_reset_values();
        full_row_store();
        column_mask();
        buffer_independence();
        back_pressure();
        instr_holdoff();
        repeat (4) @(posedge clk);
        $display("errors: %0d", err_cnt);
        if (err_cnt == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

// File: verilog/lsu_buffer_bank.sv
`timescale 1ns/100ps
`include "lsu_config.svh"

module lsu_buffer_bank (
    input  logic    clk,
    buf_wr_if.bank  wr,
    buf_rd_if.bank  rd
);
    logic [2:0]                 wr_en;
    logic [2:0]                 rd_en;
    logic [`LSU_BUF_AW-1:0]     ram_addr [3];
    logic [`LSU_ROW_W-1:0]      ram_dout [3];
    logic [1:0]                 rd_sel_q;

    // per-buffer enables, write port wins the address
    always_comb begin
        for (int i = 0; i < 3; i++) begin
            wr_en[i]    = wr.we & (wr.sel == i[1:0]);
            rd_en[i]    = rd.re & (rd.sel == i[1:0]);
            ram_addr[i] = wr_en[i] ? wr.addr : rd.addr;
        end
    end

    lsu_buffer_ram iram (.clk(clk), .ce(wr_en[0] | rd_en[0]), .we(wr_en[0]), .ben(wr.ben),
                         .addr(ram_addr[0]), .din(wr.wdata), .dout(ram_dout[0]));
    lsu_buffer_ram wram (.clk(clk), .ce(wr_en[1] | rd_en[1]), .we(wr_en[1]), .ben(wr.ben),
                         .addr(ram_addr[1]), .din(wr.wdata), .dout(ram_dout[1]));
    lsu_buffer_ram oram (.clk(clk), .ce(wr_en[2] | rd_en[2]), .we(wr_en[2]), .ben(wr.ben),
                         .addr(ram_addr[2]), .din(wr.wdata), .dout(ram_dout[2]));

    // select follows the ram read latency
    always_ff @(posedge clk) begin
        if (rd.re) begin
            rd_sel_q <= rd.sel;
        end
    end

    always_comb begin
        case (rd_sel_q)
            `LSU_BUF_IRAM: rd.rdata = ram_dout[0];
            `LSU_BUF_WRAM: rd.rdata = ram_dout[1];
            default:       rd.rdata = ram_dout[2];
        endcase
    end

    // the two engines never share a buffer cycle
    a_no_port_clash: assert property (@(posedge clk) !(|(wr_en & rd_en)));

endmodule

// File: verilog/lsu_buffer_ram.sv
`timescale 1ns/100ps

module lsu_buffer_ram #(
    parameter int AW = 8,
    parameter int NB = 16
) (
    input  logic            clk,
    input  logic            ce,
    input  logic            we,
    input  logic [NB-1:0]   ben,
    input  logic [AW-1:0]   addr,
    input  logic [NB*8-1:0] din,
    output logic [NB*8-1:0] dout
);
    logic [NB-1:0][7:0] mem [2**AW];

    // write keeps unselected bytes, read output holds during writes
    always_ff @(posedge clk) begin
        if (ce) begin
            if (we) begin
                for (int b = 0; b < NB; b++) begin
                    if (ben[b]) begin
                        mem[addr][b] <= din[b*8 +: 8];
                    end
                end
            end else begin
                dout <= mem[addr];
            end
        end
    end

endmodule

// File: verilog/lsu_dram_store.sv
`timescale 1ns/100ps
`include "lsu_config.svh"

module lsu_dram_store import lsu_pkg::*; (
    input  logic                    clk,
    input  logic                    arst_n,
    lsu_cmd_if.engine               cmd,
    buf_rd_if.master                rd,
    input  logic                    axi_awrdy,
    input  logic                    axi_wrdy,
    input  logic                    axi_bvld,
    output logic                    axi_awvld,
    output logic [`LSU_DRAM_AW-1:0] axi_awaddr,
    output logic [7:0]              axi_awlen,
    output logic                    axi_wvld,
    output logic [`LSU_BEAT_W-1:0]  axi_wdata,
    output logic                    axi_wlast,
    output logic                    axi_brdy
);
    localparam logic [2:0] S_IDLE  = 3'd0;
    localparam logic [2:0] S_ADDR  = 3'd1;
    localparam logic [2:0] S_READ  = 3'd2;
    localparam logic [2:0] S_BEAT0 = 3'd3;
    localparam logic [2:0] S_BEAT1 = 3'd4;
    localparam logic [2:0] S_RESP  = 3'd5;

    logic [2:0]             state;
    logic [2:0]             state_nxt;
    logic [`LSU_NUM_W-1:0]  row_cnt;
    logic [`LSU_BUF_AW-1:0] rd_addr;
    logic                   last_row;
    logic                   beat1_fire;
    sram_row_u              row_q;

    assign last_row   = (row_cnt == cmd.num - 1'b1);
    assign beat1_fire = (state == S_BEAT1) & axi_wrdy;

    always_comb begin
        state_nxt = state;
        case (state)
            S_IDLE:  if (cmd.start) state_nxt = S_ADDR;
            S_ADDR:  if (axi_awrdy) state_nxt = S_READ;
            // read data lands here, one cycle after re
            S_READ:  state_nxt = S_BEAT0;
            S_BEAT0: if (axi_wrdy) state_nxt = S_BEAT1;
            S_BEAT1: if (axi_wrdy) state_nxt = last_row ? S_RESP : S_READ;
            S_RESP:  if (axi_bvld) state_nxt = S_IDLE;
            default: state_nxt = S_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state   <= S_IDLE;
            row_cnt <= '0;
            rd_addr <= '0;
        end else begin
            state <= state_nxt;
            if (cmd.start) begin
                row_cnt <= '0;
                rd_addr <= cmd.buf_addr;
            end else begin
                if (beat1_fire) begin
                    row_cnt <= row_cnt + 1'b1;
                end
                if (rd.re) begin
                    rd_addr <= rd_addr + 1'b1;
                end
            end
        end
    end

    // hold the row while both beats wait on wready
    always_ff @(posedge clk) begin
        if (state == S_READ) begin
            row_q <= rd.rdata;
        end
    end

    // first row after aw, next row when beat 1 of the previous one leaves
    assign rd.re   = ((state == S_ADDR) & axi_awrdy) | (beat1_fire & ~last_row);
    assign rd.sel  = cmd.buf_sel;
    assign rd.addr = rd_addr;

    assign axi_awvld  = (state == S_ADDR);
    assign axi_awaddr = cmd.dram_addr;
    // two beats per row
    assign axi_awlen  = {cmd.num[`LSU_NUM_W-2:0], 1'b0} - 1'b1;

    assign axi_wvld  = (state == S_BEAT0) | (state == S_BEAT1);
    assign axi_wdata = (state == S_BEAT1) ? row_q.beats[1] : row_q.beats[0];
    assign axi_wlast = (state == S_BEAT1) & last_row;
    assign axi_brdy  = (state == S_RESP);

    assign cmd.done = (state == S_RESP) & axi_bvld;

    // no write data until the address has been taken
    // and the address and length hold while awvld waits
    a_aw_first: assert property (@(posedge clk) disable iff (!arst_n)
        (axi_awvld && !axi_awrdy) |=> (axi_awvld && !axi_wvld &&
                                       $stable(axi_awaddr) && $stable(axi_awlen)));

endmodule

// File: verilog/lsu_if.sv
`timescale 1ns/100ps
`include "lsu_config.svh"

// command from the instruction controller to one store engine
interface lsu_cmd_if;
    logic                    start;
    logic [1:0]              buf_sel;
    logic [`LSU_BUF_AW-1:0]  buf_addr;
    logic [`LSU_NUM_W-1:0]   num;
    logic [3:0]              start_x;
    logic [3:0]              start_y;
    logic [4:0]              len;
    logic [`LSU_DRAM_AW-1:0] dram_addr;
    logic                    done;

    modport ctrl (output start, buf_sel, buf_addr, num, start_x, start_y, len, dram_addr,
                  input done);
    modport engine (input start, buf_sel, buf_addr, num, start_x, start_y, len, dram_addr,
                    output done);
endinterface

// buffer write port, written in the cycle we is high
interface buf_wr_if import lsu_pkg::*; ();
    logic                      we;
    logic [1:0]                sel;
    logic [`LSU_BUF_AW-1:0]    addr;
    logic [`LSU_ROW_BYTES-1:0] ben;
    sram_row_u                 wdata;

    modport master (output we, sel, addr, ben, wdata);
    modport bank (input we, sel, addr, ben, wdata);
endinterface

// buffer read port, rdata one cycle after re
interface buf_rd_if import lsu_pkg::*; ();
    logic                   re;
    logic [1:0]             sel;
    logic [`LSU_BUF_AW-1:0] addr;
    sram_row_u              rdata;

    modport master (output re, sel, addr, input rdata);
    modport bank (input re, sel, addr, output rdata);
endinterface

// File: verilog/lsu_instr_ctrl.sv
`timescale 1ns/100ps
`include "lsu_config.svh"

module lsu_instr_ctrl (
    input  logic                    clk,
    input  logic                    arst_n,
    input  logic                    idu_vld,
    input  logic [1:0]              idu_op,
    input  logic [1:0]              idu_buf_sel,
    input  logic [`LSU_BUF_AW-1:0]  idu_buf_addr,
    input  logic [`LSU_NUM_W-1:0]   idu_num,
    input  logic [3:0]              idu_start_x,
    input  logic [3:0]              idu_start_y,
    input  logic [4:0]              idu_len,
    input  logic [`LSU_DRAM_AW-1:0] idu_dram_addr,
    output logic                    idu_rdy,
    lsu_cmd_if.ctrl                 mxu_cmd,
    lsu_cmd_if.ctrl                 dram_cmd
);
    logic                    busy;
    logic [1:0]              op_q;
    logic                    mxu_start_q;
    logic                    dram_start_q;
    logic                    accept;
    logic                    done_sel;
    logic [1:0]              buf_sel_q;
    logic [`LSU_BUF_AW-1:0]  buf_addr_q;
    logic [`LSU_NUM_W-1:0]   num_q;
    logic [3:0]              start_x_q;
    logic [3:0]              start_y_q;
    logic [4:0]              len_q;
    logic [`LSU_DRAM_AW-1:0] dram_addr_q;

    assign accept = idu_vld & idu_rdy;

    // only the engine that was started can finish the instruction
    assign done_sel = (op_q == `LSU_OP_ST_DRAM) ? dram_cmd.done : mxu_cmd.done;

    // ready again in the done cycle so back-to-back instructions lose nothing
    assign idu_rdy = ~busy | done_sel;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            busy         <= 1'b0;
            op_q         <= `LSU_OP_ST_BUF;
            mxu_start_q  <= 1'b0;
            dram_start_q <= 1'b0;
        end else begin
            mxu_start_q  <= accept & (idu_op == `LSU_OP_ST_BUF);
            dram_start_q <= accept & (idu_op == `LSU_OP_ST_DRAM);
            if (accept) begin
                busy <= 1'b1;
                op_q <= idu_op;
            end else if (done_sel) begin
                busy <= 1'b0;
            end
        end
    end

    // payload held until the engine reports done
    always_ff @(posedge clk) begin
        if (accept) begin
            buf_sel_q   <= idu_buf_sel;
            buf_addr_q  <= idu_buf_addr;
            num_q       <= idu_num;
            start_x_q   <= idu_start_x;
            start_y_q   <= idu_start_y;
            len_q       <= idu_len;
            dram_addr_q <= idu_dram_addr;
        end
    end

    assign mxu_cmd.start      = mxu_start_q;
    assign mxu_cmd.buf_sel    = buf_sel_q;
    assign mxu_cmd.buf_addr   = buf_addr_q;
    assign mxu_cmd.num        = num_q;
    assign mxu_cmd.start_x    = start_x_q;
    assign mxu_cmd.start_y    = start_y_q;
    assign mxu_cmd.len        = len_q;
    assign mxu_cmd.dram_addr  = dram_addr_q;

    assign dram_cmd.start     = dram_start_q;
    assign dram_cmd.buf_sel   = buf_sel_q;
    assign dram_cmd.buf_addr  = buf_addr_q;
    assign dram_cmd.num       = num_q;
    assign dram_cmd.start_x   = start_x_q;
    assign dram_cmd.start_y   = start_y_q;
    assign dram_cmd.len       = len_q;
    assign dram_cmd.dram_addr = dram_addr_q;

    a_op_legal: assert property (@(posedge clk) disable iff (!arst_n)
        accept |-> (idu_op == `LSU_OP_ST_BUF) || (idu_op == `LSU_OP_ST_DRAM));
    a_sel_legal: assert property (@(posedge clk) disable iff (!arst_n)
        accept |-> idu_buf_sel != 2'd3);
    a_num_nonzero: assert property (@(posedge clk) disable iff (!arst_n)
        accept |-> idu_num != '0);

endmodule

// File: verilog/lsu_mxu_store.sv
`timescale 1ns/100ps
`include "lsu_config.svh"

module lsu_mxu_store import lsu_pkg::*; (
    input  logic                                clk,
    input  logic                                arst_n,
    input  logic [`LSU_MXU_ROWS*`LSU_ROW_W-1:0] mxu_rows,
    input  logic                                mxu_data_rdy,
    lsu_cmd_if.engine                           cmd,
    buf_wr_if.master                            wr
);
    logic [`LSU_MXU_ROWS-1:0][`LSU_ROW_W-1:0] row_v;
    logic                                     active;
    logic [`LSU_NUM_W-1:0]                    row_cnt;
    logic [`LSU_BUF_AW-1:0]                   addr_q;
    logic [3:0]                               row_idx;
    logic [4:0]                               col_end;
    logic                                     wr_fire;
    logic                                     last_row;
    logic [`LSU_ROW_BYTES-1:0]                ben;
    sram_row_u                                src_row;
    sram_row_u                                masked_row;

    assign row_v   = mxu_rows;
    assign row_idx = cmd.start_y + row_cnt[3:0];
    assign src_row = row_v[row_idx];

    // one past the last byte column
    assign col_end = {1'b0, cmd.start_x} + cmd.len;

    always_comb begin
        for (int b = 0; b < `LSU_ROW_BYTES; b++) begin
            ben[b] = (b >= cmd.start_x) && (b < col_end);
            masked_row.bytes[b] = ben[b] ? src_row.bytes[b] : 8'h00;
        end
    end

    // a row goes out in every cycle the mxu has data
    assign wr_fire  = active & mxu_data_rdy;
    assign last_row = (row_cnt == cmd.num - 1'b1);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            active  <= 1'b0;
            row_cnt <= '0;
            addr_q  <= '0;
        end else if (cmd.start) begin
            active  <= 1'b1;
            row_cnt <= '0;
            addr_q  <= cmd.buf_addr;
        end else if (wr_fire) begin
            row_cnt <= row_cnt + 1'b1;
            addr_q  <= addr_q + 1'b1;
            if (last_row) begin
                active <= 1'b0;
            end
        end
    end

    assign wr.we    = wr_fire;
    assign wr.sel   = cmd.buf_sel;
    assign wr.addr  = addr_q;
    assign wr.ben   = ben;
    assign wr.wdata = masked_row;

    assign cmd.done = wr_fire & last_row;

    // window must stay inside the 16x16 mxu result
    a_window: assert property (@(posedge clk) disable iff (!arst_n)
        cmd.start |-> (col_end <= 5'd16) &&
                      ({5'd0, cmd.start_y} + {1'b0, cmd.num} <= 9'd16));

endmodule

// File: verilog/lsu_pkg.sv
`include "lsu_config.svh"

package lsu_pkg;

    // one buffer row
    // bytes for column masking on the mxu side,
    // beats for splitting into axi words (beat 0 is the low half)
    typedef union packed {
        logic [`LSU_ROW_BYTES-1:0][7:0] bytes;
        logic [1:0][`LSU_BEAT_W-1:0]    beats;
    } sram_row_u;

endpackage

// File: verilog/lsu_top.sv
`timescale 1ns/100ps
`include "lsu_config.svh"

module lsu_top (
    input  logic                                  clk,
    input  logic                                  arst_n,
    // decode unit
    input  logic                                  idu_vld,
    input  logic [1:0]                            idu_op,
    input  logic [1:0]                            idu_buf_sel,
    input  logic [`LSU_BUF_AW-1:0]                idu_buf_addr,
    input  logic [`LSU_NUM_W-1:0]                 idu_num,
    input  logic [3:0]                            idu_start_x,
    input  logic [3:0]                            idu_start_y,
    input  logic [4:0]                            idu_len,
    input  logic [`LSU_DRAM_AW-1:0]               idu_dram_addr,
    output logic                                  idu_rdy,
    // mxu rows, row r at bits r*128 upward
    input  logic [`LSU_MXU_ROWS*`LSU_ROW_W-1:0]   mxu_rows,
    input  logic                                  mxu_data_rdy,
    // axi write channel
    input  logic                                  axi_awrdy,
    input  logic                                  axi_wrdy,
    input  logic                                  axi_bvld,
    output logic                                  axi_awvld,
    output logic [`LSU_DRAM_AW-1:0]               axi_awaddr,
    output logic [7:0]                            axi_awlen,
    output logic                                  axi_wvld,
    output logic [`LSU_BEAT_W-1:0]                axi_wdata,
    output logic                                  axi_wlast,
    output logic                                  axi_brdy
);
    lsu_cmd_if mxu_cmd ();
    lsu_cmd_if dram_cmd ();
    buf_wr_if  buf_wr ();
    buf_rd_if  buf_rd ();

    lsu_instr_ctrl instr_ctrl (
        .clk          (clk),
        .arst_n       (arst_n),
        .idu_vld      (idu_vld),
        .idu_op       (idu_op),
        .idu_buf_sel  (idu_buf_sel),
        .idu_buf_addr (idu_buf_addr),
        .idu_num      (idu_num),
        .idu_start_x  (idu_start_x),
        .idu_start_y  (idu_start_y),
        .idu_len      (idu_len),
        .idu_dram_addr(idu_dram_addr),
        .idu_rdy      (idu_rdy),
        .mxu_cmd      (mxu_cmd),
        .dram_cmd     (dram_cmd)
    );

    lsu_mxu_store mxu_store (
        .clk         (clk),
        .arst_n      (arst_n),
        .mxu_rows    (mxu_rows),
        .mxu_data_rdy(mxu_data_rdy),
        .cmd         (mxu_cmd),
        .wr          (buf_wr)
    );

    lsu_dram_store dram_store (
        .clk       (clk),
        .arst_n    (arst_n),
        .cmd       (dram_cmd),
        .rd        (buf_rd),
        .axi_awrdy (axi_awrdy),
        .axi_wrdy  (axi_wrdy),
        .axi_bvld  (axi_bvld),
        .axi_awvld (axi_awvld),
        .axi_awaddr(axi_awaddr),
        .axi_awlen (axi_awlen),
        .axi_wvld  (axi_wvld),
        .axi_wdata (axi_wdata),
        .axi_wlast (axi_wlast),
        .axi_brdy  (axi_brdy)
    );

    lsu_buffer_bank buffer_bank (
        .clk(clk),
        .wr (buf_wr),
        .rd (buf_rd)
    );

endmodule
